// ==== source/ipdc_pkg.sv ====
// Types and constants for one 8x8 frame of 24-bit pixels and a fixed 4x4 window, op code 101 has no member
`default_nettype none

package ipdc_pkg;

    // ------------------------------
    // Frame and window geometry
    // ------------------------------
    localparam int IMG_DIM  = 8;
    localparam int WIN_DIM  = 4;
    localparam int FB_DEPTH = IMG_DIM * IMG_DIM;

    typedef logic [7:0]                       channel_t;
    typedef logic [$clog2(IMG_DIM)-1:0]       coord_t;
    // Row in the upper half, column in the lower half
    typedef logic [2*$clog2(IMG_DIM)-1:0]     addr_t;

    localparam coord_t ORIGIN_MAX  = coord_t'(IMG_DIM - WIN_DIM);
    localparam coord_t ZOOM_ORIGIN = coord_t'(2);

    // RGB keeps R in ch0, G in ch1, B in ch2
    typedef struct packed {
        channel_t ch2;
        channel_t ch1;
        channel_t ch0;
    } pixel_t;

    // ------------------------------
    // Op codes and modes
    // ------------------------------
    typedef enum logic [2:0] {
        OP_LOAD        = 3'b000,
        OP_SHIFT_RIGHT = 3'b001,
        OP_SHIFT_DOWN  = 3'b010,
        OP_DEFAULT     = 3'b011,
        OP_ZOOM_IN     = 3'b100,
        OP_YCBCR       = 3'b110,
        OP_RGB         = 3'b111
    } op_mode_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READY,
        ST_LOAD,
        ST_ORIGIN,
        ST_DISPLAY
    } ctrl_state_t;

    typedef enum logic {
        RGB,
        YCBCR
    } color_mode_t;

    // ------------------------------
    // Internal buses
    // ------------------------------
    typedef struct packed {
        logic   we;
        addr_t  addr;
        pixel_t data;
    } fb_wr_t;

    // show clear means a zero-data beat
    typedef struct packed {
        logic valid;
        logic show;
    } out_req_t;

endpackage

`default_nettype wire

// ==== source/frame_buffer.sv ====
// Holds one frame with a synchronous write and one cycle of read latency, the array is not reset
`timescale 1ns/1ps
`default_nettype none

module frame_buffer #(
    parameter int DEPTH = 64
) (
    input  wire logic              i_clk,
    input  wire logic              i_rst_n,
    input  wire ipdc_pkg::fb_wr_t  i_wr,
    input  wire ipdc_pkg::addr_t   i_rd_addr,
    output ipdc_pkg::pixel_t       o_rd_data
);

    ipdc_pkg::pixel_t mem [DEPTH];
    ipdc_pkg::pixel_t rd_data_r;

    // Write port
    always_ff @(posedge i_clk) begin
        if (i_wr.we) begin
            mem[i_wr.addr] <= i_wr.data;
        end
    end

    // Registered read of one word every cycle
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rd_data_r <= '0;
        end else begin
            rd_data_r <= mem[i_rd_addr];
        end
    end

    assign o_rd_data = rd_data_r;

endmodule

`default_nettype wire

// ==== source/ipdc_ctrl.sv ====
// Ops are taken only in the ready state and 101 is dropped, the window scan needs 16 cycles
`timescale 1ns/1ps
`default_nettype none

module ipdc_ctrl (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,
    input  wire logic                    i_op_valid,
    input  wire ipdc_pkg::op_mode_t      i_op_mode,
    input  wire logic                    i_in_valid,
    input  wire ipdc_pkg::pixel_t        i_in_data,
    output logic                         o_in_ready,
    output ipdc_pkg::fb_wr_t             o_fb_wr,
    output ipdc_pkg::addr_t              o_rd_addr,
    output ipdc_pkg::out_req_t           o_out_req,
    output ipdc_pkg::color_mode_t        o_color_mode
);

    ipdc_pkg::ctrl_state_t state_r, state_w;
    ipdc_pkg::op_mode_t    op_r, op_w;
    ipdc_pkg::addr_t       load_addr_r, load_addr_w;
    ipdc_pkg::coord_t      org_x_r, org_x_w;
    ipdc_pkg::coord_t      org_y_r, org_y_w;
    logic [1:0]            scan_x_r, scan_x_w;
    logic [1:0]            scan_y_r, scan_y_w;
    ipdc_pkg::color_mode_t mode_r, mode_w;
    ipdc_pkg::out_req_t    req_r, req_w;
    ipdc_pkg::addr_t       rd_addr_r, rd_addr_w;

    logic load_acc;
    logic load_last;
    logic scan_x_end;
    logic scan_y_end;

    assign o_in_ready = (state_r == ipdc_pkg::ST_LOAD);
    assign load_acc   = o_in_ready & i_in_valid;
    assign load_last  = load_acc & (load_addr_r == ipdc_pkg::addr_t'(ipdc_pkg::FB_DEPTH - 1));
    assign scan_x_end = (scan_x_r == 2'(ipdc_pkg::WIN_DIM - 1));
    assign scan_y_end = (scan_y_r == 2'(ipdc_pkg::WIN_DIM - 1));

    // Pixels go straight into the memory
    assign o_fb_wr.we   = load_acc;
    assign o_fb_wr.addr = load_addr_r;
    assign o_fb_wr.data = i_in_data;

    assign o_rd_addr    = rd_addr_r;
    assign o_out_req    = req_r;
    assign o_color_mode = mode_r;

    // ------------------------------
    // Next state
    // ------------------------------
    always_comb begin
        state_w     = state_r;
        op_w        = op_r;
        load_addr_w = load_addr_r;
        org_x_w     = org_x_r;
        org_y_w     = org_y_r;
        scan_x_w    = scan_x_r;
        scan_y_w    = scan_y_r;
        mode_w      = mode_r;
        rd_addr_w   = rd_addr_r;
        req_w       = '0;

        case (state_r)
            ipdc_pkg::ST_IDLE: begin
                state_w = ipdc_pkg::ST_READY;
            end

            ipdc_pkg::ST_READY: begin
                if (i_op_valid) begin
                    op_w = i_op_mode;
                    case (i_op_mode)
                        ipdc_pkg::OP_LOAD: state_w = ipdc_pkg::ST_LOAD;
                        ipdc_pkg::OP_SHIFT_RIGHT,
                        ipdc_pkg::OP_SHIFT_DOWN,
                        ipdc_pkg::OP_DEFAULT,
                        ipdc_pkg::OP_ZOOM_IN,
                        ipdc_pkg::OP_YCBCR,
                        ipdc_pkg::OP_RGB: state_w = ipdc_pkg::ST_ORIGIN;
                        default: state_w = ipdc_pkg::ST_READY;
                    endcase
                end
            end

            ipdc_pkg::ST_LOAD: begin
                if (load_acc) begin
                    load_addr_w = load_addr_r + 1'b1;
                end
                // Done beat after the last pixel
                if (load_last) begin
                    state_w = ipdc_pkg::ST_READY;
                    req_w   = '{valid: 1'b1, show: 1'b0};
                end
            end

            ipdc_pkg::ST_ORIGIN: begin
                state_w  = ipdc_pkg::ST_DISPLAY;
                scan_x_w = '0;
                scan_y_w = '0;
                case (op_r)
                    ipdc_pkg::OP_SHIFT_RIGHT: begin
                        if (org_x_r < ipdc_pkg::ORIGIN_MAX) begin
                            org_x_w = org_x_r + 1'b1;
                        end
                    end
                    ipdc_pkg::OP_SHIFT_DOWN: begin
                        if (org_y_r < ipdc_pkg::ORIGIN_MAX) begin
                            org_y_w = org_y_r + 1'b1;
                        end
                    end
                    ipdc_pkg::OP_DEFAULT: begin
                        org_x_w = '0;
                        org_y_w = '0;
                    end
                    ipdc_pkg::OP_ZOOM_IN: begin
                        org_x_w = ipdc_pkg::ZOOM_ORIGIN;
                        org_y_w = ipdc_pkg::ZOOM_ORIGIN;
                    end
                    ipdc_pkg::OP_YCBCR: begin
                        mode_w  = ipdc_pkg::YCBCR;
                        req_w   = '{valid: 1'b1, show: 1'b0};
                        state_w = ipdc_pkg::ST_READY;
                    end
                    ipdc_pkg::OP_RGB: begin
                        mode_w  = ipdc_pkg::RGB;
                        req_w   = '{valid: 1'b1, show: 1'b0};
                        state_w = ipdc_pkg::ST_READY;
                    end
                    default: state_w = ipdc_pkg::ST_READY;
                endcase
            end

            ipdc_pkg::ST_DISPLAY: begin
                // Raster scan of the window with one read per cycle
                rd_addr_w = {org_y_r + ipdc_pkg::coord_t'(scan_y_r),
                             org_x_r + ipdc_pkg::coord_t'(scan_x_r)};
                req_w     = '{valid: 1'b1, show: 1'b1};
                scan_x_w  = scan_x_r + 1'b1;
                if (scan_x_end) begin
                    scan_y_w = scan_y_r + 1'b1;
                    if (scan_y_end) begin
                        state_w = ipdc_pkg::ST_READY;
                    end
                end
            end

            default: state_w = ipdc_pkg::ST_IDLE;
        endcase
    end

    // ------------------------------
    // Registers
    // ------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r     <= ipdc_pkg::ST_IDLE;
            op_r        <= ipdc_pkg::OP_LOAD;
            load_addr_r <= '0;
            org_x_r     <= '0;
            org_y_r     <= '0;
            scan_x_r    <= '0;
            scan_y_r    <= '0;
            mode_r      <= ipdc_pkg::RGB;
            req_r       <= '0;
        end else begin
            state_r     <= state_w;
            op_r        <= op_w;
            load_addr_r <= load_addr_w;
            org_x_r     <= org_x_w;
            org_y_r     <= org_y_w;
            scan_x_r    <= scan_x_w;
            scan_y_r    <= scan_y_w;
            mode_r      <= mode_w;
            req_r       <= req_w;
        end
    end

    always_ff @(posedge i_clk) begin
        rd_addr_r <= rd_addr_w;
    end

endmodule

`default_nettype wire

// ==== source/pixel_formatter.sv ====
// Expects read data one cycle after the request, YCbCr uses truncated shift-and-add terms
`timescale 1ns/1ps
`default_nettype none

module pixel_formatter (
    input  wire logic                    i_clk,
    input  wire logic                    i_rst_n,
    input  wire ipdc_pkg::out_req_t      i_req,
    input  wire ipdc_pkg::color_mode_t   i_color_mode,
    input  wire ipdc_pkg::pixel_t        i_pixel,
    output logic                         o_out_valid,
    output ipdc_pkg::pixel_t             o_out_data
);

    ipdc_pkg::out_req_t req_d_r;
    ipdc_pkg::channel_t r;
    ipdc_pkg::channel_t g;
    ipdc_pkg::channel_t b;
    ipdc_pkg::pixel_t   ycc;
    ipdc_pkg::pixel_t   out_data_w;

    assign r = i_pixel.ch0;
    assign g = i_pixel.ch1;
    assign b = i_pixel.ch2;

    // ------------------------------
    // Colour conversion
    // ------------------------------
    // Each result stays within 8 bits so the wrap in between is harmless
    always_comb begin
        ycc.ch0 = (r >> 2) + (g >> 1) + (b >> 3);
        ycc.ch1 = 8'd128 - (r >> 3) - (g >> 2) + (b >> 1);
        ycc.ch2 = 8'd128 + (r >> 1) - (g >> 2) - (b >> 3);
    end

    always_comb begin
        if (!req_d_r.show) begin
            out_data_w = '0;
        end else if (i_color_mode == ipdc_pkg::YCBCR) begin
            out_data_w = ycc;
        end else begin
            out_data_w = i_pixel;
        end
    end

    // ------------------------------
    // Request delay and output stage
    // ------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            req_d_r     <= '0;
            o_out_valid <= 1'b0;
            o_out_data  <= '0;
        end else begin
            req_d_r     <= i_req;
            o_out_valid <= req_d_r.valid;
            o_out_data  <= out_data_w;
        end
    end

endmodule

`default_nettype wire

// ==== source/ipdc_top.sv ====
// Output has no back-pressure and every beat must be taken on its cycle
`timescale 1ns/1ps
`default_nettype none

module ipdc_top (
    input  wire logic                i_clk,
    input  wire logic                i_rst_n,
    input  wire logic                i_op_valid,
    input  wire ipdc_pkg::op_mode_t  i_op_mode,
    input  wire logic                i_in_valid,
    input  wire ipdc_pkg::pixel_t    i_in_data,
    output wire logic                o_in_ready,
    output wire logic                o_out_valid,
    output wire ipdc_pkg::pixel_t    o_out_data
);

    ipdc_pkg::fb_wr_t      fb_wr;
    ipdc_pkg::addr_t       rd_addr;
    ipdc_pkg::pixel_t      rd_pixel;
    ipdc_pkg::out_req_t    out_req;
    ipdc_pkg::color_mode_t color_mode;

    ipdc_ctrl ctrl_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_op_valid   (i_op_valid),
        .i_op_mode    (i_op_mode),
        .i_in_valid   (i_in_valid),
        .i_in_data    (i_in_data),
        .o_in_ready   (o_in_ready),
        .o_fb_wr      (fb_wr),
        .o_rd_addr    (rd_addr),
        .o_out_req    (out_req),
        .o_color_mode (color_mode)
    );

    frame_buffer #(
        .DEPTH (ipdc_pkg::FB_DEPTH)
    ) frame_buffer_i (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wr      (fb_wr),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_pixel)
    );

    pixel_formatter pixel_formatter_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_req        (out_req),
        .i_color_mode (color_mode),
        .i_pixel      (rd_pixel),
        .o_out_valid  (o_out_valid),
        .o_out_data   (o_out_data)
    );

endmodule

`default_nettype wire

// ==== sim/tb_ipdc_tasks.svh ====
// Included inside the testbench module and uses its model state, each op goes out after the previous burst has ended
`ifndef TB_IPDC_TASKS_SVH
`define TB_IPDC_TASKS_SVH

    // ------------------------------
    // Op and burst helpers
    // ------------------------------
    task automatic issue_op(input ipdc_pkg::op_mode_t op, output int acc_cyc);
        @(posedge i_clk);
        i_op_valid <= 1'b1;
        i_op_mode  <= op;
        @(posedge i_clk);
        // cyc takes this edge into account only after its update
        acc_cyc     = cyc + 1;
        i_op_valid <= 1'b0;
    endtask

    task automatic collect_beats(input int n, input int first);
        int waited;
        int i;
        waited = 0;
        while (beat_q.size() < n && waited < BEAT_WAIT) begin
            @(posedge i_clk);
            waited++;
        end
        // Extra beats would show up here
        repeat (4) @(posedge i_clk);
        if (beat_q.size() == 0) begin
            errors++;
            $display("No output beat arrived within %0d cycles at %0t ns", BEAT_WAIT, $time);
        end else if (beat_q.size() != n) begin
            errors++;
            $display("Burst at %0t ns had %0d beats instead of %0d", $time, beat_q.size(), n);
        end
        for (i = 0; i < beat_q.size() && i < n; i++) begin
            check_value("beat cycle", beat_cyc_q[i], first + i);
        end
    endtask

    task automatic expect_zero_beat(input int first);
        collect_beats(1, first);
        if (beat_q.size() > 0) begin
            check_value("o_out_data", beat_q[0], '0);
        end
    endtask

    task automatic show_window(input ipdc_pkg::op_mode_t op, input logic stray);
        int acc;
        int i;
        beat_q.delete();
        beat_cyc_q.delete();
        issue_op(op, acc);
        case (op)
            ipdc_pkg::OP_SHIFT_RIGHT: org_x_m = (org_x_m < 4) ? org_x_m + 1 : org_x_m;
            ipdc_pkg::OP_SHIFT_DOWN:  org_y_m = (org_y_m < 4) ? org_y_m + 1 : org_y_m;
            ipdc_pkg::OP_ZOOM_IN: begin
                org_x_m = 2;
                org_y_m = 2;
            end
            default: begin
                org_x_m = 0;
                org_y_m = 0;
            end
        endcase
        // An op in the middle of the scan must be dropped
        if (stray) begin
            repeat (6) @(posedge i_clk);
            i_op_valid <= 1'b1;
            i_op_mode  <= ipdc_pkg::OP_DEFAULT;
            @(posedge i_clk);
            i_op_valid <= 1'b0;
        end
        collect_beats(WIN_PIX, acc + 4);
        for (i = 0; i < beat_q.size() && i < WIN_PIX; i++) begin
            check_value("o_out_data", beat_q[i], expected_pixel(
                org_x_m + i % ipdc_pkg::WIN_DIM, org_y_m + i / ipdc_pkg::WIN_DIM));
        end
    endtask

    task automatic set_mode(input ipdc_pkg::op_mode_t op);
        int acc;
        beat_q.delete();
        beat_cyc_q.delete();
        issue_op(op, acc);
        ycbcr_m = (op == ipdc_pkg::OP_YCBCR);
        expect_zero_beat(acc + 3);
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------
    task automatic load_random_frame();
        int acc;
        int k;
        for (k = 0; k < ipdc_pkg::FB_DEPTH; k++) begin
            frame_m[k] = 24'(rand_bits(24));
        end
        beat_q.delete();
        beat_cyc_q.delete();
        issue_op(ipdc_pkg::OP_LOAD, acc);
        load_on = 1'b1;
        k = 0;
        while (k < ipdc_pkg::FB_DEPTH) begin
            // About one cycle in four is a gap
            if (rand_bits(2) == 0) begin
                i_in_valid <= 1'b0;
            end else begin
                i_in_valid <= 1'b1;
                i_in_data  <= frame_m[k];
                k++;
            end
            @(posedge i_clk);
        end
        load_on     = 1'b0;
        i_in_valid <= 1'b0;
        // Done beat two edges after the last accept
        expect_zero_beat(cyc + 3);
    endtask

    task automatic show_default_and_zoom();
        show_window(ipdc_pkg::OP_DEFAULT, 1'b0);
        show_window(ipdc_pkg::OP_ZOOM_IN, 1'b0);
    endtask

    task automatic walk_window_shifts();
        show_window(ipdc_pkg::OP_ZOOM_IN, 1'b0);
        repeat (3) show_window(ipdc_pkg::OP_SHIFT_RIGHT, 1'b0);
        repeat (3) show_window(ipdc_pkg::OP_SHIFT_DOWN, 1'b0);
    endtask

    task automatic switch_color_mode();
        set_mode(ipdc_pkg::OP_YCBCR);
        show_window(ipdc_pkg::OP_DEFAULT, 1'b0);
        show_window(ipdc_pkg::OP_ZOOM_IN, 1'b0);
        set_mode(ipdc_pkg::OP_RGB);
        show_window(ipdc_pkg::OP_SHIFT_RIGHT, 1'b0);
    endtask

    task automatic send_ignored_ops();
        int acc;
        beat_q.delete();
        beat_cyc_q.delete();
        issue_op(ipdc_pkg::op_mode_t'(3'b101), acc);
        repeat (BEAT_WAIT) @(posedge i_clk);
        if (beat_q.size() != 0) begin
            errors++;
            $display("Op code 101 gave %0d output beats, expected none", beat_q.size());
        end
        show_window(ipdc_pkg::OP_SHIFT_DOWN, 1'b1);
        show_window(ipdc_pkg::OP_SHIFT_RIGHT, 1'b0);
    endtask

`endif

// ==== sim/tb_ipdc.sv ====
// Assumes the DUT is ready two cycles after reset, frame data comes from an LFSR with a fixed seed
`timescale 1ns/1ps
`default_nettype none

module tb_ipdc;

    localparam int WIN_PIX   = ipdc_pkg::WIN_DIM * ipdc_pkg::WIN_DIM;
    localparam int BEAT_WAIT = 40;
    // Load worst case plus windows, mode ops and the ignored op
    localparam int N_STEPS   = 18;
    localparam int CYC_LIMIT = 20 + 4 * ipdc_pkg::FB_DEPTH + N_STEPS * (BEAT_WAIT + 8);

    logic               i_clk;
    logic               i_rst_n;
    logic               i_op_valid;
    ipdc_pkg::op_mode_t i_op_mode;
    logic               i_in_valid;
    ipdc_pkg::pixel_t   i_in_data;
    logic               o_in_ready;
    logic               o_out_valid;
    ipdc_pkg::pixel_t   o_out_data;

    // Reference model state
    ipdc_pkg::pixel_t   frame_m [ipdc_pkg::FB_DEPTH];
    int                 org_x_m;
    int                 org_y_m;
    logic               ycbcr_m;
    logic               load_on;

    logic [15:0]        lfsr;
    int                 cyc;
    int                 errors;
    int                 checks;
    ipdc_pkg::pixel_t   beat_q [$];
    int                 beat_cyc_q [$];

    ipdc_top dut_i (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_op_valid  (i_op_valid),
        .i_op_mode   (i_op_mode),
        .i_in_valid  (i_in_valid),
        .i_in_data   (i_in_data),
        .o_in_ready  (o_in_ready),
        .o_out_valid (o_out_valid),
        .o_out_data  (o_out_data)
    );

    always #2 i_clk = ~i_clk;

    // 16-bit Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic ipdc_pkg::pixel_t expected_pixel(input int x, input int y);
        ipdc_pkg::pixel_t p;
        int               r;
        int               g;
        int               b;
        p = frame_m[y * ipdc_pkg::IMG_DIM + x];
        r = p.ch0;
        g = p.ch1;
        b = p.ch2;
        if (ycbcr_m) begin
            p.ch0 = 8'(r / 4 + g / 2 + b / 8);
            p.ch1 = 8'(128 - r / 8 - g / 4 + b / 2);
            p.ch2 = 8'(128 + r / 2 - g / 4 - b / 8);
        end
        return p;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // ------------------------------
    // Monitor and timeout
    // ------------------------------
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            check_value("o_in_ready", o_in_ready, load_on);
            if (o_out_valid === 1'b1) begin
                beat_q.push_back(o_out_data);
                beat_cyc_q.push_back(cyc);
            end
        end
    end

    always @(posedge i_clk) begin
        cyc <= cyc + 1;
        if (cyc >= CYC_LIMIT) begin
            $display("Timeout: tests still running after %0d cycles, %0d errors", cyc, errors);
            $display("ERRORS FOUND");
            $finish;
        end
    end

`include "tb_ipdc_tasks.svh"

    initial begin
        i_clk      = 1'b0;
        i_rst_n    = 1'b0;
        i_op_valid = 1'b0;
        i_op_mode  = ipdc_pkg::OP_LOAD;
        i_in_valid = 1'b0;
        i_in_data  = '0;
        lfsr       = 16'd67;
        cyc        = 0;
        errors     = 0;
        checks     = 0;
        org_x_m    = 0;
        org_y_m    = 0;
        ycbcr_m    = 1'b0;
        load_on    = 1'b0;
        repeat (3) @(posedge i_clk);
        i_rst_n <= 1'b1;
        repeat (2) @(posedge i_clk);

        load_random_frame();
        show_default_and_zoom();
        walk_window_shifts();
        switch_color_mode();
        send_ignored_ops();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+sim
source/ipdc_pkg.sv
source/frame_buffer.sv
source/ipdc_ctrl.sv
source/pixel_formatter.sv
source/ipdc_top.sv
sim/tb_ipdc.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds tb_ipdc with Verilator, runs it and scans the log for the fail message

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -Wno-fatal -f filelist.f --top-module tb_ipdc \
    -Mdir "$BUILD_DIR" -o Vtb_ipdc
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_ipdc" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "ERRORS FOUND" "$LOG"; then
    echo "Simulation failed, see $LOG"
    exit 1
fi

echo "Simulation passed"
exit 0
